// ==== hw/tag_rx_pkg.sv ====
package tag_rx_pkg;

  // sample and phase widths
  localparam int data_width  = 16;
  localparam int phase_width = 24;
  localparam int gpio_width  = 12;

  typedef logic signed [data_width-1:0] sample_t;

  localparam sample_t sample_max = {1'b0, {(data_width-1){1'b1}}};
  localparam sample_t sample_min = {1'b1, {(data_width-1){1'b0}}};

  // rx_start kept for encoding compatibility, never entered
  typedef enum logic [1:0] {
    rx_init     = 2'd0,
    rx_loc_sync = 2'd1,
    rx_start    = 2'd2,
    rx_loc_rx   = 2'd3
  } rx_state_t;

  // square-wave sync magnitude
  localparam sample_t sync_level = 16384;

  // clamp a double-width value into the sample range
  function automatic sample_t sat_sample(input logic signed [2*data_width-1:0] x);
    sample_t res;
    if (x > sample_max) begin
      res = sample_max;
    end else if (x < sample_min) begin
      res = sample_min;
    end else begin
      res = x[data_width-1:0];
    end
    return res;
  endfunction

endpackage

// ==== hw/iq_scaler.sv ====
module iq_scaler #(
  parameter int scale_shift = 8
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                advance,
  input  tag_rx_pkg::sample_t gain,
  input  tag_rx_pkg::sample_t in_i,
  input  tag_rx_pkg::sample_t in_q,
  output tag_rx_pkg::sample_t scaled_i,
  output tag_rx_pkg::sample_t scaled_q
);
  import tag_rx_pkg::*;

  logic signed [2*data_width-1:0] prod_i;
  logic signed [2*data_width-1:0] prod_q;
  logic signed [2*data_width-1:0] shift_i;
  logic signed [2*data_width-1:0] shift_q;

  // full-width products, then drop the fractional bits
  assign prod_i  = gain * in_i;
  assign prod_q  = gain * in_q;
  assign shift_i = prod_i >>> scale_shift;
  assign shift_q = prod_q >>> scale_shift;

  // saturated result held until the next accept
  always_ff @(posedge clk) begin
    if (rst) begin
      scaled_i <= '0;
      scaled_q <= '0;
    end else if (advance) begin
      scaled_i <= sat_sample(shift_i);
      scaled_q <= sat_sample(shift_q);
    end
  end

endmodule

// ==== hw/preamble_detect.sv ====
module preamble_detect #(
  parameter int dec_rate     = 64,
  parameter int energy_thres = 15000
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                advance,
  input  tag_rx_pkg::sample_t scaled_i,
  input  tag_rx_pkg::sample_t scaled_q,
  output logic                peak_valid,
  output logic                peak_hit
);
  import tag_rx_pkg::*;

  localparam int cnt_width = (dec_rate > 1) ? $clog2(dec_rate) : 1;
  localparam int mag_width = data_width + 1;
  localparam int acc_width = mag_width + cnt_width + 1;

  logic [cnt_width-1:0] dec_cnt;
  logic [acc_width-1:0] energy;
  logic [acc_width-1:0] energy_next;
  logic [mag_width-1:0] abs_i;
  logic [mag_width-1:0] abs_q;
  logic                 block_end;

  // |x| in one extra bit so the most negative sample fits
  function automatic logic [mag_width-1:0] mag(input sample_t x);
    logic signed [mag_width-1:0] ext;
    ext = x;
    if (ext < 0) begin
      ext = -ext;
    end
    return ext;
  endfunction

  assign abs_i       = mag(scaled_i);
  assign abs_q       = mag(scaled_q);
  assign energy_next = energy + abs_i + abs_q;
  assign block_end   = (dec_cnt == cnt_width'(dec_rate - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_cnt    <= '0;
      energy     <= '0;
      peak_valid <= 1'b0;
      peak_hit   <= 1'b0;
    end else if (advance) begin
      if (block_end) begin
        dec_cnt    <= '0;
        energy     <= '0;
        peak_valid <= 1'b1;
        peak_hit   <= (energy_next > energy_thres);
      end else begin
        dec_cnt    <= dec_cnt + 1'b1;
        energy     <= energy_next;
        peak_valid <= 1'b0;
        peak_hit   <= 1'b0;
      end
    end
  end

endmodule

// ==== hw/rx_mixer.sv ====
module rx_mixer #(
  parameter logic [tag_rx_pkg::phase_width-1:0] ph_inc   = 24'h400000,
  parameter logic [tag_rx_pkg::phase_width-1:0] start_ph = '0,
  parameter int                                 nsymb    = 64
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                advance,
  input  logic                srst,
  input  tag_rx_pkg::sample_t scaled_i,
  input  tag_rx_pkg::sample_t scaled_q,
  output tag_rx_pkg::sample_t bb_i,
  output tag_rx_pkg::sample_t bb_q,
  output logic                sync_ready
);
  import tag_rx_pkg::*;

  localparam int symb_width = (nsymb > 0) ? $clog2(nsymb + 1) : 1;

  logic [phase_width-1:0] phase;
  logic [symb_width-1:0]  symb_cnt;
  logic [1:0]             quad;
  sample_t                rot_i;
  sample_t                rot_q;

  function automatic sample_t neg_sat(input sample_t x);
    logic signed [2*data_width-1:0] wide;
    wide = x;
    return sat_sample(-wide);
  endfunction

  // quarter turn picked by the top two phase bits
  assign quad = phase[phase_width-1 -: 2];

  always_comb begin
    case (quad)
      2'd0: begin
        rot_i = scaled_i;
        rot_q = scaled_q;
      end
      2'd1: begin
        rot_i = neg_sat(scaled_q);
        rot_q = scaled_i;
      end
      2'd2: begin
        rot_i = neg_sat(scaled_i);
        rot_q = neg_sat(scaled_q);
      end
      default: begin
        rot_i = scaled_q;
        rot_q = neg_sat(scaled_i);
      end
    endcase
  end

  assign sync_ready = (symb_cnt == symb_width'(nsymb));

  always_ff @(posedge clk) begin
    if (rst) begin
      phase    <= start_ph;
      symb_cnt <= '0;
      bb_i     <= '0;
      bb_q     <= '0;
    end else if (advance) begin
      bb_i <= rot_i;
      bb_q <= rot_q;
      if (srst) begin
        phase    <= start_ph;
        symb_cnt <= '0;
      end else begin
        phase <= phase + ph_inc;
        // stop once nsymb symbols have gone by
        if (!sync_ready) begin
          symb_cnt <= symb_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// ==== hw/tag_rx_ctrl.sv ====
module tag_rx_ctrl #(
  parameter int dec_rate = 64,
  parameter int nsyncp   = 16384,
  parameter int nsyncn   = 16384,
  parameter int nrx_trig = 16
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 advance,
  input  logic                                 run,
  input  tag_rx_pkg::sample_t                  scale_val,
  output tag_rx_pkg::sample_t                  gain,
  input  logic                                 peak_valid,
  input  logic                                 peak_hit,
  input  logic                                 sync_ready,
  input  tag_rx_pkg::sample_t                  bb_i,
  input  tag_rx_pkg::sample_t                  bb_q,
  output logic                                 mixer_srst,
  output tag_rx_pkg::sample_t                  sel_i,
  output tag_rx_pkg::sample_t                  sel_q,
  output logic                                 rx_valid,
  output logic                                 rx_trig,
  output logic                                 peak_stb,
  output tag_rx_pkg::rx_state_t                rx_state,
  output logic [tag_rx_pkg::gpio_width-1:0]    gpio_out,
  output logic [tag_rx_pkg::gpio_width-1:0]    gpio_ddr
);
  import tag_rx_pkg::*;

  // last count of the sync playout, trigger delay included
  localparam int sync_last   = nsyncp + nsyncn + (nrx_trig - 1) * dec_rate - 1;
  localparam int count_width = (sync_last > 0) ? $clog2(sync_last + 1) : 1;

  rx_state_t              state;
  logic [count_width-1:0] count;
  logic                   start_rx;
  logic                   in_sync;
  sample_t                sync_i;

  assign rx_state   = state;
  assign mixer_srst = start_rx;
  assign rx_trig    = start_rx;

  // sync pattern replaces the data while the mixer restarts
  assign in_sync = (state == rx_loc_sync);
  assign sync_i  = (count < nsyncp) ? sync_level : -sync_level;
  assign sel_i   = in_sync ? sync_i : bb_i;
  assign sel_q   = in_sync ? '0 : bb_q;

  assign peak_stb = peak_valid && peak_hit;
  assign gpio_ddr = gpio_width'(1);
  assign gpio_out = {{(gpio_width-1){1'b0}}, peak_stb};

  always_ff @(posedge clk) begin
    if (rst || !run) begin
      state    <= rx_init;
      count    <= '0;
      start_rx <= 1'b0;
      rx_valid <= 1'b0;
      gain     <= sample_t'(1);
    end else if (advance) begin
      case (state)
        rx_init: begin
          gain <= (scale_val == '0) ? sample_t'(1) : scale_val;
          if (peak_valid) begin
            if (peak_hit) begin
              state    <= rx_loc_sync;
              rx_valid <= 1'b1;
              start_rx <= 1'b1;
              count    <= '0;
            end else begin
              rx_valid <= 1'b0;
            end
          end
        end
        rx_loc_sync: begin
          if (count < sync_last) begin
            count <= count + 1'b1;
          end else begin
            start_rx <= 1'b0;
            state    <= rx_loc_rx;
          end
        end
        rx_loc_rx: begin
          // frame is over at the first block end after the symbols
          if (peak_valid && sync_ready) begin
            state <= rx_init;
          end
        end
        default: begin
          state <= rx_init;
        end
      endcase
    end
  end

endmodule

// ==== hw/out_fifo.sv ====
module out_fifo (
  input  logic                clk,
  input  logic                rst,
  input  tag_rx_pkg::sample_t in_i,
  input  tag_rx_pkg::sample_t in_q,
  input  logic                in_valid,
  output logic                not_full,
  output tag_rx_pkg::sample_t out_i,
  output tag_rx_pkg::sample_t out_q,
  output logic                out_valid,
  input  logic                out_ready
);
  import tag_rx_pkg::*;

  // input stage plus output stage, two entries in all
  sample_t hold_i;
  sample_t hold_q;
  logic    hold_full;
  logic    move;

  assign move     = hold_full && (!out_valid || out_ready);
  // room if the input stage is free or drains this cycle
  assign not_full = !hold_full || !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      hold_full <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (in_valid && not_full) begin
        hold_full <= 1'b1;
      end else if (move) begin
        hold_full <= 1'b0;
      end
      if (move) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && not_full) begin
      hold_i <= in_i;
      hold_q <= in_q;
    end
    if (move) begin
      out_i <= hold_i;
      out_q <= hold_q;
    end
  end

endmodule

// ==== hw/tag_rx_top.sv ====
module tag_rx_top #(
  parameter int                                 scale_shift  = 8,
  parameter int                                 dec_rate     = 64,
  parameter int                                 energy_thres = 15000,
  parameter logic [tag_rx_pkg::phase_width-1:0] ph_inc       = 24'h400000,
  parameter logic [tag_rx_pkg::phase_width-1:0] start_ph     = '0,
  parameter int                                 nsymb        = 64,
  parameter int                                 nsyncp       = 16384,
  parameter int                                 nsyncn       = 16384,
  parameter int                                 nrx_trig     = 16
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              in_valid,
  output logic                              in_ready,
  input  tag_rx_pkg::sample_t               in_i,
  input  tag_rx_pkg::sample_t               in_q,
  output logic                              out_valid,
  input  logic                              out_ready,
  output tag_rx_pkg::sample_t               out_i,
  output tag_rx_pkg::sample_t               out_q,
  input  logic                              run,
  input  tag_rx_pkg::sample_t               scale_val,
  output logic                              rx_valid,
  output logic                              rx_trig,
  output tag_rx_pkg::rx_state_t             rx_state,
  output logic                              peak_stb,
  output logic [tag_rx_pkg::gpio_width-1:0] gpio_out,
  output logic [tag_rx_pkg::gpio_width-1:0] gpio_ddr
);
  import tag_rx_pkg::*;

  logic    advance;
  logic    chain_rst;
  logic    not_full;
  logic    peak_valid;
  logic    peak_hit;
  logic    mixer_srst;
  logic    sync_ready;
  sample_t gain;
  sample_t scaled_i;
  sample_t scaled_q;
  sample_t bb_i;
  sample_t bb_q;
  sample_t sel_i;
  sample_t sel_q;

  // one accept moves every stage
  assign in_ready  = not_full;
  assign advance   = in_valid && not_full;
  assign chain_rst = rst || !run;

  iq_scaler #(.scale_shift(scale_shift)) scaler0 (
    .clk(clk), .rst(chain_rst), .advance(advance), .gain(gain),
    .in_i(in_i), .in_q(in_q), .scaled_i(scaled_i), .scaled_q(scaled_q));

  preamble_detect #(.dec_rate(dec_rate), .energy_thres(energy_thres)) detect0 (
    .clk(clk), .rst(chain_rst), .advance(advance), .scaled_i(scaled_i),
    .scaled_q(scaled_q), .peak_valid(peak_valid), .peak_hit(peak_hit));

  rx_mixer #(.ph_inc(ph_inc), .start_ph(start_ph), .nsymb(nsymb)) mixer0 (
    .clk(clk), .rst(chain_rst), .advance(advance), .srst(mixer_srst),
    .scaled_i(scaled_i), .scaled_q(scaled_q), .bb_i(bb_i), .bb_q(bb_q),
    .sync_ready(sync_ready));

  tag_rx_ctrl #(
    .dec_rate(dec_rate), .nsyncp(nsyncp), .nsyncn(nsyncn), .nrx_trig(nrx_trig)
  ) ctrl0 (
    .clk(clk), .rst(rst), .advance(advance), .run(run), .scale_val(scale_val),
    .gain(gain), .peak_valid(peak_valid), .peak_hit(peak_hit),
    .sync_ready(sync_ready), .bb_i(bb_i), .bb_q(bb_q), .mixer_srst(mixer_srst),
    .sel_i(sel_i), .sel_q(sel_q), .rx_valid(rx_valid), .rx_trig(rx_trig),
    .peak_stb(peak_stb), .rx_state(rx_state), .gpio_out(gpio_out),
    .gpio_ddr(gpio_ddr));

  out_fifo fifo0 (
    .clk(clk), .rst(chain_rst), .in_i(sel_i), .in_q(sel_q), .in_valid(advance),
    .not_full(not_full), .out_i(out_i), .out_q(out_q), .out_valid(out_valid),
    .out_ready(out_ready));

endmodule

// ==== tb/tag_rx_tb.sv ====
module tag_rx_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import tag_rx_pkg::*;

  localparam int dec_rate     = 4;
  localparam int energy_thres = 1000;
  localparam int nsyncp       = 8;
  localparam int nsyncn       = 8;
  localparam int nrx_trig     = 2;
  localparam int nsymb        = 12;
  localparam int scale_shift  = 8;
  localparam int sync_len     = nsyncp + nsyncn + (nrx_trig - 1) * dec_rate;
  localparam int max_cycles   = 4000;

  logic clk, rst, run, in_valid, in_ready, out_valid, out_ready;
  logic rx_valid, rx_trig, peak_stb, gaps, peak_seen;
  logic [gpio_width-1:0] gpio_out, gpio_ddr;
  logic [31:0] rng;
  sample_t in_i, in_q, out_i, out_q, scale_val;
  rx_state_t rx_state;
  int value_errors, other_errors, cycles;
  sample_t exp_i[$];
  sample_t exp_q[$];

  // reference model, one step per accepted sample
  sample_t m_sc_i, m_sc_q, m_bb_i, m_bb_q, m_gain;
  rx_state_t m_state;
  logic [1:0] m_quad;
  logic m_pv, m_ph, m_trig, m_rxv;
  int m_energy, m_dec, m_symb, m_count;

  tag_rx_top #(
    .scale_shift(scale_shift), .dec_rate(dec_rate), .energy_thres(energy_thres),
    .nsymb(nsymb), .nsyncp(nsyncp), .nsyncn(nsyncn), .nrx_trig(nrx_trig)
  ) dut0 (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_ready(in_ready), .in_i(in_i),
    .in_q(in_q), .out_valid(out_valid), .out_ready(out_ready), .out_i(out_i),
    .out_q(out_q), .run(run), .scale_val(scale_val), .rx_valid(rx_valid),
    .rx_trig(rx_trig), .rx_state(rx_state), .peak_stb(peak_stb),
    .gpio_out(gpio_out), .gpio_ddr(gpio_ddr));

  always #10 clk = ~clk;

  function automatic logic [31:0] next_random();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  function automatic sample_t noise(input int amp);
    int r;
    r = int'(next_random() % (2 * amp + 1));
    return sample_t'(r - amp);
  endfunction

  function automatic logic pick_out_ready();
    if (!gaps) return 1'b1;
    return (next_random() % 4) != 0;
  endfunction

  function automatic sample_t clamp(input longint v);
    if (v > sample_max) return sample_max;
    if (v < sample_min) return sample_min;
    return sample_t'(v);
  endfunction

  function automatic sample_t scale_ref(input sample_t x, input sample_t g);
    return clamp((longint'(g) * longint'(x)) >>> scale_shift);
  endfunction

  function automatic sample_t neg_ref(input sample_t x);
    return clamp(-longint'(x));
  endfunction

  function automatic int mag_ref(input sample_t x);
    return (x < 0) ? -int'(x) : int'(x);
  endfunction

  task automatic check_sample(input sample_t gi, gq, ei, eq);
    if (gi !== ei || gq !== eq) begin
      value_errors++;
      $display("[FAIL] %0t ns: output (%0d, %0d), expected (%0d, %0d)", $time, gi, gq, ei, eq);
    end
  endtask

  task automatic check_state(input string what, input rx_state_t got, exp);
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_flag(input string what, input logic got, exp);
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_gpio(input string what, input logic [gpio_width-1:0] got, exp);
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic model_reset();
    m_sc_i = '0;
    m_sc_q = '0;
    m_bb_i = '0;
    m_bb_q = '0;
    m_gain = sample_t'(1);
    m_state = rx_init;
    {m_quad, m_pv, m_ph, m_trig, m_rxv} = '0;
    {m_energy, m_dec, m_symb, m_count} = '0;
    exp_i.delete();
    exp_q.delete();
  endtask

  task automatic model_step(input sample_t xi, input sample_t xq);
    sample_t new_gain;
    sample_t sync_i;
    logic sr, old_trig;
    int sum;
    old_trig = m_trig;
    sr = (m_symb == nsymb);
    new_gain = m_gain;
    // sync square wave stands in for the data while the mixer restarts
    sync_i = (m_count < nsyncp) ? sync_level : -sync_level;
    exp_i.push_back((m_state == rx_loc_sync) ? sync_i : m_bb_i);
    exp_q.push_back((m_state == rx_loc_sync) ? sample_t'(0) : m_bb_q);
    case (m_state)
      rx_init: begin
        new_gain = (scale_val == 0) ? sample_t'(1) : scale_val;
        if (m_pv && m_ph) begin
          m_state = rx_loc_sync;
          m_rxv = 1'b1;
          m_trig = 1'b1;
          m_count = 0;
        end else if (m_pv) begin
          m_rxv = 1'b0;
        end
      end
      rx_loc_sync: begin
        if (m_count < sync_len - 1) begin
          m_count++;
        end else begin
          m_trig = 1'b0;
          m_state = rx_loc_rx;
        end
      end
      default: begin
        if (m_pv && sr) m_state = rx_init;
      end
    endcase
    sum = m_energy + mag_ref(m_sc_i) + mag_ref(m_sc_q);
    m_pv = (m_dec == dec_rate - 1);
    m_ph = m_pv && (sum > energy_thres);
    m_energy = m_pv ? 0 : sum;
    m_dec = m_pv ? 0 : m_dec + 1;
    case (m_quad)
      2'd0: {m_bb_i, m_bb_q} = {m_sc_i, m_sc_q};
      2'd1: {m_bb_i, m_bb_q} = {neg_ref(m_sc_q), m_sc_i};
      2'd2: {m_bb_i, m_bb_q} = {neg_ref(m_sc_i), neg_ref(m_sc_q)};
      default: {m_bb_i, m_bb_q} = {m_sc_q, neg_ref(m_sc_i)};
    endcase
    m_quad = old_trig ? 2'd0 : m_quad + 2'd1;
    m_symb = old_trig ? 0 : (sr ? m_symb : m_symb + 1);
    m_sc_i = scale_ref(xi, m_gain);
    m_sc_q = scale_ref(xq, m_gain);
    m_gain = new_gain;
  endtask

  task automatic finish_run();
    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors + other_errors == 0) $display("Finished with no errors");
    else $display("Finished with errors");
    $finish;
  endtask

  // monitor and model share the pre-edge view of every signal
  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      other_errors++;
      $display("timeout: the run did not end within %0d cycles", max_cycles);
      finish_run();
    end else if (rst) begin
      model_reset();
    end else begin
      // only a full fifo with a stalled sink refuses input
      check_flag("in_ready", in_ready, exp_i.size() != 2 || out_ready);
      if (out_valid && out_ready && exp_i.size() == 0) begin
        other_errors++;
        $display("output beat at %0t ns with no sample expected", $time);
      end else if (out_valid && out_ready) begin
        check_sample(out_i, out_q, exp_i.pop_front(), exp_q.pop_front());
      end
      check_state("rx_state", rx_state, m_state);
      check_flag("peak_stb", peak_stb, m_pv && m_ph);
      check_gpio("gpio_out", gpio_out, gpio_width'(m_pv && m_ph));
      check_gpio("gpio_ddr", gpio_ddr, gpio_width'(1));
      check_flag("rx_trig", rx_trig, m_trig);
      check_flag("rx_valid", rx_valid, m_rxv);
      if (peak_stb) peak_seen = 1'b1;
      if (!run) model_reset();
      else if (in_valid && in_ready) model_step(in_i, in_q);
    end
  end

  // called on a falling edge, returns on the falling edge after the accept
  task automatic send_sample(input sample_t xi, input sample_t xq);
    {in_valid, in_i, in_q} = {1'b1, xi, xq};
    out_ready = pick_out_ready();
    @(posedge clk);
    while (!in_ready) begin
      @(negedge clk);
      out_ready = pick_out_ready();
      @(posedge clk);
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic drain();
    out_ready = 1'b1;
    while (exp_i.size() != 0) @(negedge clk);
  endtask

  task automatic restart_chain(input sample_t scale);
    {in_valid, out_ready, run, scale_val} = {1'b0, 1'b1, 1'b0, scale};
    @(negedge clk);
    run = 1'b1;
  endtask

  task automatic detect_preamble();
    for (int n = 0; n < 16 && rx_state != rx_loc_sync; n++) send_sample(3000, -3000);
  endtask

  task automatic test_scaling();
    gaps = 1'b1;
    restart_chain(512);
    send_sample(40, -25);
    send_sample(-60, 30);
    send_sample(12, 0);
    send_sample(20000, -20000);
    send_sample(16383, -16384);
    send_sample(-32768, 32767);
    send_sample(300, -5000);
    repeat (6) send_sample(noise(100), noise(100));
    drain();
    restart_chain(0);
    send_sample(30000, -30000);
    send_sample(255, -256);
    repeat (8) send_sample(noise(20000), noise(20000));
    drain();
    gaps = 1'b0;
  endtask

  task automatic test_threshold();
    restart_chain(256);
    peak_seen = 1'b0;
    repeat (7) send_sample(noise(100), noise(100));
    // third block sums to exactly the threshold
    repeat (4) send_sample(200, -50);
    send_sample(0, 0);
    check_state("rx_state after quiet noise", rx_state, rx_init);
    check_flag("peak_stb during quiet noise", peak_seen || peak_stb, 1'b0);
    detect_preamble();
    check_flag("peak_stb on loud block", peak_seen, 1'b1);
    check_state("rx_state after loud block", rx_state, rx_loc_sync);
  endtask

  task automatic test_sync_pattern();
    int n;
    n = 0;
    while (rx_state == rx_loc_sync && n < 2 * sync_len) begin
      check_flag("rx_trig during sync", rx_trig, 1'b1);
      send_sample(noise(8000), noise(8000));
      n++;
    end
    check_flag("sync playout length", n == sync_len, 1'b1);
    check_state("rx_state after sync", rx_state, rx_loc_rx);
  endtask

  task automatic test_rotation();
    int n;
    n = 0;
    gaps = 1'b1;
    while (rx_state == rx_loc_rx && n < 40) begin
      send_sample(noise(8000), noise(8000));
      n++;
    end
    check_state("rx_state after frame", rx_state, rx_init);
    if (n < nsymb + 1 || n > nsymb + dec_rate) begin
      other_errors++;
      $display("receive frame lasted %0d samples instead of %0d to %0d", n, nsymb + 1,
               nsymb + dec_rate);
    end
    drain();
    gaps = 1'b0;
  endtask

  task automatic test_run_low();
    restart_chain(256);
    detect_preamble();
    check_state("rx_state before run low", rx_state, rx_loc_sync);
    repeat (5) send_sample(noise(8000), noise(8000));
    run = 1'b0;
    @(negedge clk);
    check_state("rx_state after run low", rx_state, rx_init);
    check_flag("rx_valid after run low", rx_valid, 1'b0);
    run = 1'b1;
  endtask

  initial begin
    {clk, rst, run, in_valid, out_ready, gaps, peak_seen} = 7'b0110100;
    {in_i, in_q, scale_val} = {16'sd0, 16'sd0, 16'sd256};
    rng = 32'h6cf8bf56;
    {value_errors, other_errors, cycles} = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_scaling();
    test_threshold();
    test_sync_pattern();
    test_rotation();
    test_run_low();
    drain();
    finish_run();
  end

endmodule

// ==== tag_rx.f ====
hw/tag_rx_pkg.sv
hw/iq_scaler.sv
hw/preamble_detect.sv
hw/rx_mixer.sv
hw/tag_rx_ctrl.sv
hw/out_fifo.sv
hw/tag_rx_top.sv
tb/tag_rx_tb.sv
